//--- src/idStage_cfg.svh
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

// datapath and register file sizing
`define XLEN 32
`define REG_ADDR_W 5
`define NUM_REGS 32

`define LINK_REG 31 // jal destination

`endif

//--- src/mipsIsaPkg.sv
package mipsIsaPkg;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDI    = 6'h08,
        ADDIU   = 6'h09,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        XORI    = 6'h0e,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        SLLV = 6'h04,
        SRLV = 6'h06,
        SRAV = 6'h07,
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a
    } funct_e;

endpackage

//--- src/idCtrlPkg.sv
package idCtrlPkg;

    typedef enum logic [4:0] {
        NOP,
        ADD,
        ADDU,
        SUB,
        SUBU,
        AND,
        OR,
        XOR,
        NOR,
        SLT,
        SLL,
        SRL,
        SRA,
        LOAD,
        STORE,
        LINK    // jal, passes pc+4 through
    } aluOp_e;

    typedef enum logic [1:0] {
        REG,
        SIGN_IMM,
        ZERO_IMM,
        SHAMT
    } opBSrc_e;

    typedef enum logic [2:0] {
        NONE,
        EQ,
        NE,
        JUMP,
        JUMP_REG
    } branchKind_e;

endpackage

//--- src/instrDecoder.sv
`include "idStage_cfg.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]        instr_i,
    output logic [`REG_ADDR_W-1:0]  rsAddr_o,
    output logic [`REG_ADDR_W-1:0]  rtAddr_o,
    output logic                    rsUsed_o,
    output logic                    rtUsed_o,
    output idCtrlPkg::aluOp_e       aluOp_o,
    output idCtrlPkg::opBSrc_e      opBSrc_o,
    output logic [15:0]             imm_o,
    output logic [4:0]              shamt_o,
    output logic                    wbEn_o,
    output logic [`REG_ADDR_W-1:0]  wbAddr_o,
    output idCtrlPkg::branchKind_e  branchKind_o,
    output logic [25:0]             jumpIndex_o,
    output logic                    isStore_o
);

    mipsIsaPkg::opcode_e    opcode;
    mipsIsaPkg::funct_e     funct;
    logic [`REG_ADDR_W-1:0] rdAddr;

    // variable shifts share the ALU op of their constant form
    function automatic idCtrlPkg::aluOp_e functAluOp(input mipsIsaPkg::funct_e f);
        case (f)
            mipsIsaPkg::ADD:  return idCtrlPkg::ADD;
            mipsIsaPkg::ADDU: return idCtrlPkg::ADDU;
            mipsIsaPkg::SUB:  return idCtrlPkg::SUB;
            mipsIsaPkg::SUBU: return idCtrlPkg::SUBU;
            mipsIsaPkg::AND:  return idCtrlPkg::AND;
            mipsIsaPkg::OR:   return idCtrlPkg::OR;
            mipsIsaPkg::XOR:  return idCtrlPkg::XOR;
            mipsIsaPkg::NOR:  return idCtrlPkg::NOR;
            mipsIsaPkg::SLT:  return idCtrlPkg::SLT;
            mipsIsaPkg::SLL, mipsIsaPkg::SLLV: return idCtrlPkg::SLL;
            mipsIsaPkg::SRL, mipsIsaPkg::SRLV: return idCtrlPkg::SRL;
            mipsIsaPkg::SRA, mipsIsaPkg::SRAV: return idCtrlPkg::SRA;
            default:          return idCtrlPkg::NOP; // jr and unknown
        endcase
    endfunction

    assign opcode      = mipsIsaPkg::opcode_e'(instr_i[31:26]);
    assign funct       = mipsIsaPkg::funct_e'(instr_i[5:0]);
    assign rsAddr_o    = instr_i[25:21];
    assign rtAddr_o    = instr_i[20:16];
    assign rdAddr      = instr_i[15:11];
    assign shamt_o     = instr_i[10:6];
    assign imm_o       = instr_i[15:0];
    assign jumpIndex_o = instr_i[25:0];

    always_comb begin
        rsUsed_o     = 1'b0;
        rtUsed_o     = 1'b0;
        aluOp_o      = idCtrlPkg::NOP;
        opBSrc_o     = idCtrlPkg::REG;
        wbEn_o       = 1'b0;
        wbAddr_o     = '0;
        branchKind_o = idCtrlPkg::NONE;
        isStore_o    = 1'b0;
        case (opcode)
            mipsIsaPkg::SPECIAL: begin
                aluOp_o = functAluOp(funct);
                case (funct)
                    mipsIsaPkg::ADD, mipsIsaPkg::ADDU, mipsIsaPkg::SUB, mipsIsaPkg::SUBU,
                    mipsIsaPkg::AND, mipsIsaPkg::OR, mipsIsaPkg::XOR, mipsIsaPkg::NOR,
                    mipsIsaPkg::SLT, mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV: begin
                        rsUsed_o = 1'b1;
                        rtUsed_o = 1'b1;
                        wbEn_o   = 1'b1;
                        wbAddr_o = rdAddr;
                    end
                    mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA: begin
                        rtUsed_o = 1'b1;
                        opBSrc_o = idCtrlPkg::SHAMT;
                        wbEn_o   = 1'b1;
                        wbAddr_o = rdAddr;
                    end
                    mipsIsaPkg::JR: begin
                        rsUsed_o     = 1'b1;
                        branchKind_o = idCtrlPkg::JUMP_REG;
                    end
                    default: ;
                endcase
            end
            mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::LW: begin
                rsUsed_o = 1'b1;
                opBSrc_o = idCtrlPkg::SIGN_IMM;
                wbEn_o   = 1'b1;
                wbAddr_o = rtAddr_o;
                if (opcode == mipsIsaPkg::ADDI)
                    aluOp_o = idCtrlPkg::ADD;
                else if (opcode == mipsIsaPkg::ADDIU)
                    aluOp_o = idCtrlPkg::ADDU;
                else
                    aluOp_o = idCtrlPkg::LOAD;
            end
            mipsIsaPkg::ANDI, mipsIsaPkg::ORI, mipsIsaPkg::XORI: begin
                rsUsed_o = 1'b1;
                opBSrc_o = idCtrlPkg::ZERO_IMM;
                wbEn_o   = 1'b1;
                wbAddr_o = rtAddr_o;
                if (opcode == mipsIsaPkg::ANDI)
                    aluOp_o = idCtrlPkg::AND;
                else if (opcode == mipsIsaPkg::ORI)
                    aluOp_o = idCtrlPkg::OR;
                else
                    aluOp_o = idCtrlPkg::XOR;
            end
            mipsIsaPkg::SW: begin
                rsUsed_o  = 1'b1;
                rtUsed_o  = 1'b1;
                opBSrc_o  = idCtrlPkg::SIGN_IMM; // address offset
                aluOp_o   = idCtrlPkg::STORE;
                isStore_o = 1'b1;
            end
            mipsIsaPkg::BEQ, mipsIsaPkg::BNE: begin
                rsUsed_o     = 1'b1;
                rtUsed_o     = 1'b1;
                branchKind_o = (opcode == mipsIsaPkg::BEQ) ? idCtrlPkg::EQ : idCtrlPkg::NE;
            end
            mipsIsaPkg::J: branchKind_o = idCtrlPkg::JUMP;
            mipsIsaPkg::JAL: begin
                branchKind_o = idCtrlPkg::JUMP;
                aluOp_o      = idCtrlPkg::LINK;
                wbEn_o       = 1'b1;
                wbAddr_o     = `REG_ADDR_W'(`LINK_REG);
            end
            default: ;
        endcase
    end

endmodule

//--- src/regFile.sv
`include "idStage_cfg.svh"

module regFile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  rdAddrA_i,
    input  logic [`REG_ADDR_W-1:0]  rdAddrB_i,
    input  logic                    wrEn_i,
    input  logic [`REG_ADDR_W-1:0]  wrAddr_i,
    input  logic [`XLEN-1:0]        wrData_i,
    output logic [`XLEN-1:0]        rdDataA_o,
    output logic [`XLEN-1:0]        rdDataB_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wrLive;

    assign wrLive = wrEn_i && (wrAddr_i != '0); // r0 is hardwired

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // write-through so decode sees this cycle's writeback
    assign rdDataA_o = (wrLive && wrAddr_i == rdAddrA_i) ? wrData_i : regs[rdAddrA_i];
    assign rdDataB_o = (wrLive && wrAddr_i == rdAddrB_i) ? wrData_i : regs[rdAddrB_i];

endmodule

//--- src/operandForward.sv
`include "idStage_cfg.svh"

module operandForward (
    input  logic [`REG_ADDR_W-1:0]  srcAddr_i,
    input  logic                    srcUsed_i,
    input  logic [`XLEN-1:0]        rfData_i,
    input  logic                    exWriteBack_i,
    input  logic                    exIsLoad_i,
    input  logic [`REG_ADDR_W-1:0]  exAddr_i,
    input  logic [`XLEN-1:0]        exData_i,
    input  logic                    memWrite_i,
    input  logic [`REG_ADDR_W-1:0]  memAddr_i,
    input  logic [`XLEN-1:0]        memData_i,
    output logic [`XLEN-1:0]        value_o,
    output logic                    loadHazard_o
);

    logic exHit;
    logic memHit;

    // load data is not ready in execute, so it never forwards from there
    assign exHit  = exWriteBack_i && !exIsLoad_i && (exAddr_i == srcAddr_i);
    assign memHit = memWrite_i && (memAddr_i == srcAddr_i);

    assign loadHazard_o = srcUsed_i && exIsLoad_i && (exAddr_i != '0)
                          && (exAddr_i == srcAddr_i);

    always_comb begin
        if (!srcUsed_i || srcAddr_i == '0)
            value_o = '0;
        else if (exHit)
            value_o = exData_i; // youngest result wins
        else if (memHit)
            value_o = memData_i;
        else
            value_o = rfData_i;
    end

endmodule

//--- src/branchUnit.sv
`include "idStage_cfg.svh"

module branchUnit (
    input  logic [`XLEN-1:0]        pc_i,
    input  idCtrlPkg::branchKind_e  branchKind_i,
    input  logic [15:0]             imm_i,
    input  logic [25:0]             jumpIndex_i,
    input  logic [`XLEN-1:0]        rsValue_i,
    input  logic [`XLEN-1:0]        rtValue_i,
    output logic                    taken_o,
    output logic [`XLEN-1:0]        target_o,
    output logic [`XLEN-1:0]        pcPlus4_o
);

    logic [`XLEN-1:0] relTarget;
    logic [`XLEN-1:0] absTarget;
    logic             equal;

    assign pcPlus4_o = pc_i + 4;
    assign relTarget = pcPlus4_o + {{(`XLEN-18){imm_i[15]}}, imm_i, 2'b00};
    assign absTarget = {pcPlus4_o[`XLEN-1:`XLEN-4], jumpIndex_i, 2'b00}; // same 256MB region
    assign equal     = (rsValue_i == rtValue_i);

    always_comb begin
        taken_o  = 1'b0;
        target_o = '0;
        case (branchKind_i)
            idCtrlPkg::EQ: begin
                taken_o  = equal;
                target_o = equal ? relTarget : '0;
            end
            idCtrlPkg::NE: begin
                taken_o  = !equal;
                target_o = equal ? '0 : relTarget;
            end
            idCtrlPkg::JUMP: begin
                taken_o  = 1'b1;
                target_o = absTarget;
            end
            idCtrlPkg::JUMP_REG: begin
                taken_o  = 1'b1;
                target_o = rsValue_i;
            end
            default: ;
        endcase
    end

endmodule

//--- src/idStage.sv
`include "idStage_cfg.svh"

module idStage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    instrValid_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        instr_i,
    input  logic                    wbEn_i,
    input  logic [`REG_ADDR_W-1:0]  wbAddr_i,
    input  logic [`XLEN-1:0]        wbData_i,
    input  logic                    exWriteBack_i,
    input  logic                    exIsLoad_i,
    input  logic [`REG_ADDR_W-1:0]  exAddr_i,
    input  logic [`XLEN-1:0]        exData_i,
    input  logic                    memWrite_i,
    input  logic [`REG_ADDR_W-1:0]  memAddr_i,
    input  logic [`XLEN-1:0]        memData_i,
    output logic                    outValid_o,
    output logic                    stall_o,
    output idCtrlPkg::aluOp_e       aluOp_o,
    output logic [`XLEN-1:0]        operandA_o,
    output logic [`XLEN-1:0]        operandB_o,
    output logic [`XLEN-1:0]        storeData_o,
    output logic                    wbEnOut_o,
    output logic [`REG_ADDR_W-1:0]  wbAddrOut_o,
    output logic                    branchEn_o,
    output logic [`XLEN-1:0]        branchTarget_o
);

    logic [`REG_ADDR_W-1:0] rsAddr, rtAddr, decWbAddr;
    logic                   rsUsed, rtUsed, decWbEn, isStore;
    idCtrlPkg::aluOp_e      aluOp;
    idCtrlPkg::opBSrc_e     opBSrc;
    idCtrlPkg::branchKind_e branchKind;
    logic [15:0]            imm;
    logic [4:0]             shamt;
    logic [25:0]            jumpIndex;
    logic [`XLEN-1:0]       rfRs, rfRt, rsValue, rtValue;
    logic                   rsHazard, rtHazard, hazard;
    logic                   taken;
    logic [`XLEN-1:0]       target, pcPlus4;
    logic                   isShift;
    logic [`XLEN-1:0]       opA, opB, storeData;

    instrDecoder decoder (
        .instr_i(instr_i), .rsAddr_o(rsAddr), .rtAddr_o(rtAddr),
        .rsUsed_o(rsUsed), .rtUsed_o(rtUsed), .aluOp_o(aluOp), .opBSrc_o(opBSrc),
        .imm_o(imm), .shamt_o(shamt), .wbEn_o(decWbEn), .wbAddr_o(decWbAddr),
        .branchKind_o(branchKind), .jumpIndex_o(jumpIndex), .isStore_o(isStore)
    );

    regFile regs (
        .clk(clk), .reset(reset), .rdAddrA_i(rsAddr), .rdAddrB_i(rtAddr),
        .wrEn_i(wbEn_i), .wrAddr_i(wbAddr_i), .wrData_i(wbData_i),
        .rdDataA_o(rfRs), .rdDataB_o(rfRt)
    );

    operandForward fwdRs (
        .srcAddr_i(rsAddr), .srcUsed_i(rsUsed), .rfData_i(rfRs),
        .exWriteBack_i(exWriteBack_i), .exIsLoad_i(exIsLoad_i), .exAddr_i(exAddr_i),
        .exData_i(exData_i), .memWrite_i(memWrite_i), .memAddr_i(memAddr_i),
        .memData_i(memData_i), .value_o(rsValue), .loadHazard_o(rsHazard)
    );

    operandForward fwdRt (
        .srcAddr_i(rtAddr), .srcUsed_i(rtUsed), .rfData_i(rfRt),
        .exWriteBack_i(exWriteBack_i), .exIsLoad_i(exIsLoad_i), .exAddr_i(exAddr_i),
        .exData_i(exData_i), .memWrite_i(memWrite_i), .memAddr_i(memAddr_i),
        .memData_i(memData_i), .value_o(rtValue), .loadHazard_o(rtHazard)
    );

    branchUnit branch (
        .pc_i(pc_i), .branchKind_i(branchKind), .imm_i(imm), .jumpIndex_i(jumpIndex),
        .rsValue_i(rsValue), .rtValue_i(rtValue),
        .taken_o(taken), .target_o(target), .pcPlus4_o(pcPlus4)
    );

    assign hazard  = rsHazard | rtHazard;
    assign isShift = (aluOp == idCtrlPkg::SLL) || (aluOp == idCtrlPkg::SRL)
                     || (aluOp == idCtrlPkg::SRA);
    assign storeData = isStore ? rtValue : '0;

    always_comb begin
        if (aluOp == idCtrlPkg::LINK)
            opA = pcPlus4;
        else if (isShift)
            opA = rtValue; // shifts operate on rt
        else
            opA = rsValue;
        case (opBSrc)
            idCtrlPkg::SIGN_IMM: opB = {{(`XLEN-16){imm[15]}}, imm};
            idCtrlPkg::ZERO_IMM: opB = {{(`XLEN-16){1'b0}}, imm};
            idCtrlPkg::SHAMT:    opB = {{(`XLEN-5){1'b0}}, shamt};
            default:             opB = isShift ? rsValue : rtValue; // rs is the amount for *v
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid_o     <= 1'b0;
            stall_o        <= 1'b0;
            aluOp_o        <= idCtrlPkg::NOP;
            operandA_o     <= '0;
            operandB_o     <= '0;
            storeData_o    <= '0;
            wbEnOut_o      <= 1'b0;
            wbAddrOut_o    <= '0;
            branchEn_o     <= 1'b0;
            branchTarget_o <= '0;
        end else begin
            outValid_o <= instrValid_i && !hazard;
            stall_o    <= instrValid_i && hazard; // upstream re-issues
            if (instrValid_i && !hazard) begin
                aluOp_o        <= aluOp;
                operandA_o     <= opA;
                operandB_o     <= opB;
                storeData_o    <= storeData;
                wbEnOut_o      <= decWbEn;
                wbAddrOut_o    <= decWbAddr;
                branchEn_o     <= taken;
                branchTarget_o <= target;
            end
        end
    end

endmodule

//--- verification/idStageModel.svh
`ifndef ID_STAGE_MODEL_SVH
`define ID_STAGE_MODEL_SVH

function automatic logic [1:0] srcUse(input logic [31:0] ins); // {rs, rt}
    case (mipsIsaPkg::opcode_e'(ins[31:26]))
        mipsIsaPkg::SPECIAL: begin
            case (mipsIsaPkg::funct_e'(ins[5:0]))
                mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA: return 2'b01;
                mipsIsaPkg::JR: return 2'b10;
                mipsIsaPkg::ADD, mipsIsaPkg::ADDU, mipsIsaPkg::SUB, mipsIsaPkg::SUBU,
                mipsIsaPkg::AND, mipsIsaPkg::OR, mipsIsaPkg::XOR, mipsIsaPkg::NOR,
                mipsIsaPkg::SLT, mipsIsaPkg::SLLV, mipsIsaPkg::SRLV,
                mipsIsaPkg::SRAV: return 2'b11;
                default: return 2'b00;
            endcase
        end
        mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::ANDI, mipsIsaPkg::ORI,
        mipsIsaPkg::XORI, mipsIsaPkg::LW: return 2'b10;
        mipsIsaPkg::SW, mipsIsaPkg::BEQ, mipsIsaPkg::BNE: return 2'b11;
        default: return 2'b00;
    endcase
endfunction

function automatic idCtrlPkg::aluOp_e aluOf(input logic [31:0] ins);
    case (mipsIsaPkg::opcode_e'(ins[31:26]))
        mipsIsaPkg::SPECIAL: begin
            case (mipsIsaPkg::funct_e'(ins[5:0]))
                mipsIsaPkg::ADD:  return idCtrlPkg::ADD;
                mipsIsaPkg::ADDU: return idCtrlPkg::ADDU;
                mipsIsaPkg::SUB:  return idCtrlPkg::SUB;
                mipsIsaPkg::SUBU: return idCtrlPkg::SUBU;
                mipsIsaPkg::AND:  return idCtrlPkg::AND;
                mipsIsaPkg::OR:   return idCtrlPkg::OR;
                mipsIsaPkg::XOR:  return idCtrlPkg::XOR;
                mipsIsaPkg::NOR:  return idCtrlPkg::NOR;
                mipsIsaPkg::SLT:  return idCtrlPkg::SLT;
                mipsIsaPkg::SLL, mipsIsaPkg::SLLV: return idCtrlPkg::SLL;
                mipsIsaPkg::SRL, mipsIsaPkg::SRLV: return idCtrlPkg::SRL;
                mipsIsaPkg::SRA, mipsIsaPkg::SRAV: return idCtrlPkg::SRA;
                default: return idCtrlPkg::NOP;
            endcase
        end
        mipsIsaPkg::ADDI:  return idCtrlPkg::ADD;
        mipsIsaPkg::ADDIU: return idCtrlPkg::ADDU;
        mipsIsaPkg::ANDI:  return idCtrlPkg::AND;
        mipsIsaPkg::ORI:   return idCtrlPkg::OR;
        mipsIsaPkg::XORI:  return idCtrlPkg::XOR;
        mipsIsaPkg::LW:    return idCtrlPkg::LOAD;
        mipsIsaPkg::SW:    return idCtrlPkg::STORE;
        mipsIsaPkg::JAL:   return idCtrlPkg::LINK;
        default:           return idCtrlPkg::NOP;
    endcase
endfunction

function automatic logic [5:0] destOf(input logic [31:0] ins); // {enable, address}
    logic [1:0] srcs;
    srcs = srcUse(ins);
    case (mipsIsaPkg::opcode_e'(ins[31:26]))
        mipsIsaPkg::SPECIAL: return srcs[0] ? {1'b1, ins[15:11]} : 6'h00; // not jr
        mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::ANDI, mipsIsaPkg::ORI,
        mipsIsaPkg::XORI, mipsIsaPkg::LW: return {1'b1, ins[20:16]};
        mipsIsaPkg::JAL: return {1'b1, 5'(`LINK_REG)};
        default: return 6'h00;
    endcase
endfunction

function automatic logic isShiftInstr(input logic [31:0] ins);
    if (ins[31:26] != mipsIsaPkg::SPECIAL)
        return 1'b0;
    case (mipsIsaPkg::funct_e'(ins[5:0]))
        mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA,
        mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// reads the forwarding inputs and shadow registers of the including module
// unused sources read as zero
function automatic logic [`XLEN-1:0] srcValue(input logic [4:0] a, input logic used);
    if (!used || a == '0)
        return '0;
    if (exWriteBack && !exIsLoad && exAddr == a)
        return exData;
    if (memWrite && memAddr == a)
        return memData;
    if (wbEn && wbAddr == a)
        return wbData; // write-through
    return shadow[a];
endfunction

function automatic logic [`XLEN-1:0] operandAOf(input logic [31:0] ins,
                                                input logic [`XLEN-1:0] pcVal,
                                                input logic [`XLEN-1:0] rsv,
                                                input logic [`XLEN-1:0] rtv);
    if (ins[31:26] == mipsIsaPkg::JAL)
        return pcVal + 32'd4;
    return isShiftInstr(ins) ? rtv : rsv;
endfunction

function automatic logic [`XLEN-1:0] operandBOf(input logic [31:0] ins,
                                                input logic [`XLEN-1:0] rsv,
                                                input logic [`XLEN-1:0] rtv);
    case (mipsIsaPkg::opcode_e'(ins[31:26]))
        mipsIsaPkg::SPECIAL: begin
            case (mipsIsaPkg::funct_e'(ins[5:0]))
                mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA:
                    return {{(`XLEN-5){1'b0}}, ins[10:6]};
                mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV: return rsv;
                default: return rtv; // zero when rt is unused
            endcase
        end
        mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::LW, mipsIsaPkg::SW:
            return {{(`XLEN-16){ins[15]}}, ins[15:0]};
        mipsIsaPkg::ANDI, mipsIsaPkg::ORI, mipsIsaPkg::XORI:
            return {{(`XLEN-16){1'b0}}, ins[15:0]};
        mipsIsaPkg::BEQ, mipsIsaPkg::BNE: return rtv;
        default: return '0;
    endcase
endfunction

function automatic logic [`XLEN:0] branchOf(input logic [31:0] ins,
                                            input logic [`XLEN-1:0] pcVal,
                                            input logic [`XLEN-1:0] rsv,
                                            input logic [`XLEN-1:0] rtv); // {taken, target}
    logic [`XLEN-1:0] next;
    logic [`XLEN-1:0] rel;
    next = pcVal + 32'd4;
    rel  = next + ({{(`XLEN-16){ins[15]}}, ins[15:0]} << 2);
    case (mipsIsaPkg::opcode_e'(ins[31:26]))
        mipsIsaPkg::BEQ: return (rsv == rtv) ? {1'b1, rel} : '0;
        mipsIsaPkg::BNE: return (rsv != rtv) ? {1'b1, rel} : '0;
        mipsIsaPkg::J, mipsIsaPkg::JAL: return {1'b1, next[31:28], ins[25:0], 2'b00};
        mipsIsaPkg::SPECIAL: return (ins[5:0] == mipsIsaPkg::JR) ? {1'b1, rsv} : '0;
        default: return '0;
    endcase
endfunction

`endif

//--- verification/idStageTb.sv
`include "idStage_cfg.svh"

module idStageTb;

    localparam int resetCycles = 16;
    localparam int clkPeriod   = 40;
    localparam int numRandom   = 1500;
    localparam int numInstr    = `NUM_REGS + numRandom; // register sweep, then random

    logic                   clk;
    logic                   reset;
    logic                   instrValid;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       instr;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   exWriteBack;
    logic                   exIsLoad;
    logic [`REG_ADDR_W-1:0] exAddr;
    logic [`XLEN-1:0]       exData;
    logic                   memWrite;
    logic [`REG_ADDR_W-1:0] memAddr;
    logic [`XLEN-1:0]       memData;
    logic                   outValid;
    logic                   stall;
    idCtrlPkg::aluOp_e      aluOp;
    logic [`XLEN-1:0]       operandA;
    logic [`XLEN-1:0]       operandB;
    logic [`XLEN-1:0]       storeData;
    logic                   wbEnOut;
    logic [`REG_ADDR_W-1:0] wbAddrOut;
    logic                   branchEn;
    logic [`XLEN-1:0]       branchTarget;

    logic [`XLEN-1:0]       shadow [`NUM_REGS];
    logic [31:0]            rngState;
    logic                   expValid, expStall, expWbEn, expTaken;
    idCtrlPkg::aluOp_e      expAlu;
    logic [`REG_ADDR_W-1:0] expWbAddr;
    logic [`XLEN-1:0]       expA, expB, expStore, expTarget;
    int                     ctrlErrors, dataErrors, branchErrors, stallErrors;

    logic [5:0] functList [16] = '{mipsIsaPkg::SLL, mipsIsaPkg::SRL, mipsIsaPkg::SRA,
        mipsIsaPkg::SLLV, mipsIsaPkg::SRLV, mipsIsaPkg::SRAV, mipsIsaPkg::JR,
        mipsIsaPkg::ADD, mipsIsaPkg::ADDU, mipsIsaPkg::SUB, mipsIsaPkg::SUBU,
        mipsIsaPkg::AND, mipsIsaPkg::OR, mipsIsaPkg::XOR, mipsIsaPkg::NOR, mipsIsaPkg::SLT};
    logic [5:0] opcodeList [11] = '{mipsIsaPkg::ADDI, mipsIsaPkg::ADDIU, mipsIsaPkg::ANDI,
        mipsIsaPkg::ORI, mipsIsaPkg::XORI, mipsIsaPkg::LW, mipsIsaPkg::SW,
        mipsIsaPkg::BEQ, mipsIsaPkg::BNE, mipsIsaPkg::J, mipsIsaPkg::JAL};

    `include "idStageModel.svh"

    idStage uut (
        .clk(clk), .reset(reset), .instrValid_i(instrValid), .pc_i(pc), .instr_i(instr),
        .wbEn_i(wbEn), .wbAddr_i(wbAddr), .wbData_i(wbData),
        .exWriteBack_i(exWriteBack), .exIsLoad_i(exIsLoad), .exAddr_i(exAddr),
        .exData_i(exData), .memWrite_i(memWrite), .memAddr_i(memAddr), .memData_i(memData),
        .outValid_o(outValid), .stall_o(stall), .aluOp_o(aluOp),
        .operandA_o(operandA), .operandB_o(operandB), .storeData_o(storeData),
        .wbEnOut_o(wbEnOut), .wbAddrOut_o(wbAddrOut),
        .branchEn_o(branchEn), .branchTarget_o(branchTarget)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // small register window most of the time, so hits are common
    function automatic logic [4:0] pickReg(input logic [31:0] r);
        return r[3] ? r[8:4] : {2'b00, r[2:0]};
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r        = rngState;
    endtask

    task automatic randomInstr(output logic [31:0] ins);
        logic [31:0] r;
        logic [31:0] f;
        int          sel;
        nextRandom(ins);
        nextRandom(r);
        nextRandom(f);
        sel         = int'(r % 32'd30);
        ins[25:21]  = pickReg(f);
        ins[20:16]  = pickReg(f >> 9);
        ins[15:11]  = pickReg(f >> 18);
        if (sel < 16) begin
            ins[31:26] = mipsIsaPkg::SPECIAL;
            ins[5:0]   = functList[sel];
        end else if (sel < 27) begin
            ins[31:26] = opcodeList[sel - 16];
        end else if (sel < 29) begin
            ins[31:26] = {4'hf, r[31:30]}; // 0x3c..0x3f are unassigned
        end else begin
            ins[31:26] = mipsIsaPkg::SPECIAL;
            ins[5:0]   = 6'h3f;
        end
    endtask

    task automatic driveInputs(input bit sweep, input int n);
        logic [31:0] r;
        nextRandom(r);
        instrValid  = sweep || (r[2:0] != 3'b000); // idle about one cycle in eight
        exWriteBack = !sweep && r[3];
        exIsLoad    = !sweep && (r[5:4] == 2'b11);
        memWrite    = !sweep && r[6];
        wbEn        = !sweep && r[7];
        exAddr      = pickReg(r >> 8);
        memAddr     = pickReg(r >> 17);
        nextRandom(r);
        wbAddr = pickReg(r);
        pc     = {r[31:10], r[11:4], 2'b00};
        nextRandom(exData);
        nextRandom(memData);
        nextRandom(wbData);
        if (sweep)
            instr = {mipsIsaPkg::SPECIAL, n[4:0], n[4:0], 5'd1, 5'd0, mipsIsaPkg::ADD};
        else
            randomInstr(instr);
    endtask

    task automatic predict();
        logic [1:0]       srcs;
        logic [5:0]       dst;
        logic [`XLEN-1:0] rsv;
        logic [`XLEN-1:0] rtv;
        logic             hazard;
        srcs   = srcUse(instr);
        rsv    = srcValue(instr[25:21], srcs[1]);
        rtv    = srcValue(instr[20:16], srcs[0]);
        hazard = exIsLoad && exAddr != '0
                 && ((srcs[1] && exAddr == instr[25:21]) || (srcs[0] && exAddr == instr[20:16]));
        expValid = instrValid && !hazard;
        expStall = instrValid && hazard;
        if (expValid) begin // outputs hold otherwise
            dst       = destOf(instr);
            expAlu    = aluOf(instr);
            expWbEn   = dst[5];
            expWbAddr = dst[4:0];
            expA      = operandAOf(instr, pc, rsv, rtv);
            expB      = operandBOf(instr, rsv, rtv);
            expStore  = (instr[31:26] == mipsIsaPkg::SW) ? rtv : '0;
            {expTaken, expTarget} = branchOf(instr, pc, rsv, rtv);
        end
    endtask

    task automatic checkControl(input idCtrlPkg::aluOp_e got, input idCtrlPkg::aluOp_e exp,
                                input logic gotEn, input logic expEn,
                                input logic [`REG_ADDR_W-1:0] gotAddr,
                                input logic [`REG_ADDR_W-1:0] expAddr);
        if (got !== exp) begin
            $display("[FAIL] aluOp_o got %h expected %h", got, exp);
            ctrlErrors++;
        end
        if (gotEn !== expEn || gotAddr !== expAddr) begin
            $display("[FAIL] wbEnOut_o/wbAddrOut_o got %h/%h expected %h/%h",
                     gotEn, gotAddr, expEn, expAddr);
            ctrlErrors++;
        end
    endtask

    task automatic checkData(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkBranch(input logic gotTaken, input logic expTakenV,
                               input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (gotTaken !== expTakenV || got !== exp) begin
            $display("[FAIL] branchEn_o/branchTarget_o got %h/%h expected %h/%h",
                     gotTaken, got, expTakenV, exp);
            branchErrors++;
        end
    endtask

    task automatic checkStall(input logic gotStall, input logic gotValid,
                              input logic expStallV, input logic expValidV);
        if (expValidV && gotValid !== 1'b1) begin
            $display("no result pulse on outValid_o one cycle after the strobe at %0t", $time);
            stallErrors++;
        end else if (gotValid !== expValidV) begin
            $display("[FAIL] outValid_o got %h expected %h", gotValid, expValidV);
            stallErrors++;
        end
        if (expStallV && gotStall !== 1'b1) begin
            $display("no stall pulse for a load-use hazard at %0t", $time);
            stallErrors++;
        end else if (gotStall !== expStallV) begin
            $display("[FAIL] stall_o got %h expected %h", gotStall, expStallV);
            stallErrors++;
        end
    endtask

    task automatic checkOutputs();
        checkStall(stall, outValid, expStall, expValid);
        checkControl(aluOp, expAlu, wbEnOut, expWbEn, wbAddrOut, expWbAddr);
        checkData("operandA_o", operandA, expA);
        checkData("operandB_o", operandB, expB);
        checkData("storeData_o", storeData, expStore);
        checkBranch(branchEn, expTaken, branchTarget, expTarget);
    endtask

    initial begin
        #((resetCycles + numInstr * 2 + 50) * clkPeriod);
        $display("watchdog expired before the instruction stream completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instrValid = 1'b0;
        pc = '0;
        instr = '0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        exWriteBack = 1'b0;
        exIsLoad = 1'b0;
        exAddr = '0;
        exData = '0;
        memWrite = 1'b0;
        memAddr = '0;
        memData = '0;
        rngState = 32'h3463_c3e0;
        {expValid, expStall, expWbEn, expTaken} = 4'b0000;
        expAlu = idCtrlPkg::NOP;
        expWbAddr = '0;
        {expA, expB, expStore, expTarget} = '0;
        ctrlErrors = 0;
        dataErrors = 0;
        branchErrors = 0;
        stallErrors = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkOutputs(); // reset state

        for (int n = 0; n < numInstr; n++) begin
            @(negedge clk);
            driveInputs(n < `NUM_REGS, n);
            predict();
            @(posedge clk);
            #1;
            checkOutputs();
            if (wbEn && wbAddr != '0)
                shadow[wbAddr] = wbData;
        end

        $display("errors: control %0d, data %0d, branch %0d, stall %0d",
                 ctrlErrors, dataErrors, branchErrors, stallErrors);
        if (ctrlErrors + dataErrors + branchErrors + stallErrors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- idStage.f
+incdir+src
+incdir+verification
src/mipsIsaPkg.sv
src/idCtrlPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/operandForward.sv
src/branchUnit.sv
src/idStage.sv
verification/idStageTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f idStage.f --top-module idStageTb -o idStageSim

output=$(./obj_dir/idStageSim)
echo "$output"

# the grep status decides the script status
echo "$output" | grep -q "^TEST PASSED$"
